// File: hdl/rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu import rv_core_pkg::*; (
  input  ctl_t            ctl,
  input  logic [xlen-1:0] a1,   // rs1 or pc
  input  logic [xlen-1:0] a2,   // rs2 or imm
  input  logic [xlen-1:0] rs1,  // raw registers for compare
  input  logic [xlen-1:0] rs2,
  output logic [xlen-1:0] rd,
  output logic [xlen-1:0] sum,
  output logic            tkn
);

logic [4:0] sh;  // shift amount

assign sh  = a2[4:0];
assign sum = a1 + a2;  // ls address, jump and branch target

//////////////////////////////////////////////////////////////////////
// result
//////////////////////////////////////////////////////////////////////

always_comb begin
  case (ctl.alu)
    alu_add:  rd = sum;
    alu_sub:  rd = a1 - a2;
    alu_sll:  rd = a1 << sh;
    alu_slt:  rd = xlen'($signed(a1) < $signed(a2));
    alu_sltu: rd = xlen'(a1 < a2);
    alu_xor:  rd = a1 ^ a2;
    alu_srl:  rd = a1 >> sh;
    alu_sra:  rd = $unsigned($signed(a1) >>> sh);
    alu_or:   rd = a1 | a2;
    alu_and:  rd = a1 & a2;
    default:  rd = sum;
  endcase
end

//////////////////////////////////////////////////////////////////////
// branch condition
//////////////////////////////////////////////////////////////////////

always_comb begin
  case (ctl.br)
    br_eq:   tkn = (rs1 == rs2);
    br_ne:   tkn = (rs1 != rs2);
    br_lt:   tkn = ($signed(rs1) <  $signed(rs2));
    br_ge:   tkn = ($signed(rs1) >= $signed(rs2));
    br_ltu:  tkn = (rs1 <  rs2);
    br_geu:  tkn = (rs1 >= rs2);
    default: tkn = 1'b0;  // not a branch
  endcase
end

endmodule

`default_nettype wire

// File: hdl/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_core_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  // program bus
  output logic            if_req,
  output ibus_req_t       if_req_p,
  input  op_t             if_rdt,
  input  logic            if_ack,
  // data bus
  output logic            ls_req,
  output dbus_req_t       ls_req_p,
  input  logic [xlen-1:0] ls_rdt,
  input  logic            ls_ack
);

//////////////////////////////////////////////////////////////////////
// signals
//////////////////////////////////////////////////////////////////////

logic            if_run;   // out of reset
logic [xlen-1:0] pc;       // address of the decoded instruction
logic [xlen-1:0] pci;      // pc + 4
logic [xlen-1:0] pcn;      // next pc, also the fetch address
logic            stall;
logic            ls_done;  // data phase over, waiting for the fetch

op_t             id_op;
ctl_t            id_ctl;
ctl_t            lsu_ctl;  // id_ctl with the access masked
logic            id_vld;

logic [xlen-1:0] gpr_rs1, gpr_rs2, gpr_rd;
logic            gpr_we;
logic [xlen-1:0] alu_a1, alu_a2, alu_rd, alu_sum;
logic            alu_tkn;
logic [xlen-1:0] lsu_rdt;
logic            lsu_dly;

//////////////////////////////////////////////////////////////////////
// fetch and stall
//////////////////////////////////////////////////////////////////////

always_ff @(posedge clk, posedge rst) begin
  if (rst) if_run <= 1'b0;
  else     if_run <= 1'b1;
end

// off during a load, and during a store until its ack
assign if_req       = if_run & ~(ls_req & ~(ls_req_p.we & ls_ack));
assign if_req_p.adr = pcn;

assign stall = (if_req & ~if_ack)   // fetch waiting
             | (ls_req & ~ls_ack)   // data access waiting
             | (ls_req & ~ls_req_p.we);  // first load cycle

always_ff @(posedge clk, posedge rst) begin
  if (rst) id_vld <= 1'b0;
  else     id_vld <= (if_req & if_ack) | (id_vld & stall);
end

// fetched word only valid with the ack
always_ff @(posedge clk) begin
  if (if_req & if_ack) id_op <= if_rdt;
end

// keeps a finished access from repeating while the fetch waits
always_ff @(posedge clk, posedge rst) begin
  if (rst) ls_done <= 1'b0;
  else     ls_done <= (ls_done | (ls_req & ls_ack)) & ~(if_req & if_ack);
end

//////////////////////////////////////////////////////////////////////
// program counter
//////////////////////////////////////////////////////////////////////

assign pci = pc + 32'd4;

always_comb begin
  if (!id_vld) begin
    pcn = pc;  // first fetch after reset
  end else begin
    case (id_ctl.pc)
      pc_brn:  pcn = alu_tkn ? alu_sum : pci;
      pc_jmp:  pcn = {alu_sum[xlen-1:1], 1'b0};
      default: pcn = pci;
    endcase
  end
end

always_ff @(posedge clk, posedge rst) begin
  if (rst)                  pc <= pc0;
  else if (id_vld & ~stall) pc <= pcn;  // retire
end

//////////////////////////////////////////////////////////////////////
// decode and execute
//////////////////////////////////////////////////////////////////////

rv_dec dec0 (
  .op  (id_op),
  .ctl (id_ctl)
);

// loads write on the delayed flag, the rest at retire
assign gpr_we = id_vld & id_ctl.rd_en & ((id_ctl.wb == wb_mem) ? lsu_dly : ~stall);

rv_gpr gpr0 (
  .clk     (clk),
  .rst     (rst),
  .rs1_en  (id_ctl.rs1_en),
  .rs2_en  (id_ctl.rs2_en),
  .rd_en   (gpr_we),
  .rs1_adr (id_ctl.rs1_adr),
  .rs2_adr (id_ctl.rs2_adr),
  .rd_adr  (id_ctl.rd_adr),
  .rs1_dat (gpr_rs1),
  .rs2_dat (gpr_rs2),
  .rd_dat  (gpr_rd)
);

assign alu_a1 = (id_ctl.a1 == a1_pc ) ? pc         : gpr_rs1;
assign alu_a2 = (id_ctl.a2 == a2_imm) ? id_ctl.imm : gpr_rs2;

rv_alu alu0 (
  .ctl (id_ctl),
  .a1  (alu_a1),
  .a2  (alu_a2),
  .rs1 (gpr_rs1),
  .rs2 (gpr_rs2),
  .rd  (alu_rd),
  .sum (alu_sum),
  .tkn (alu_tkn)
);

//////////////////////////////////////////////////////////////////////
// load/store and write back
//////////////////////////////////////////////////////////////////////

always_comb begin
  lsu_ctl       = id_ctl;
  lsu_ctl.ls_en = id_ctl.ls_en & id_vld & ~ls_done;  // nothing before the first fetch
end

rv_lsu lsu0 (
  .clk      (clk),
  .rst      (rst),
  .ctl      (lsu_ctl),
  .adr      (alu_sum),
  .wdt      (gpr_rs2),
  .ls_req   (ls_req),
  .ls_req_p (ls_req_p),
  .ls_rdt   (ls_rdt),
  .ls_ack   (ls_ack),
  .rdt      (lsu_rdt),
  .dly      (lsu_dly)
);

always_comb begin
  case (id_ctl.wb)
    wb_alu:  gpr_rd = alu_rd;
    wb_mem:  gpr_rd = lsu_rdt;
    wb_pci:  gpr_rd = pci;         // link
    wb_imm:  gpr_rd = id_ctl.imm;  // lui
    default: gpr_rd = '0;
  endcase
end

endmodule

`default_nettype wire

// File: hdl/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

//////////////////////////////////////////////////////////////////////
// widths and constants
//////////////////////////////////////////////////////////////////////

localparam int unsigned     xlen = 32;  // register and data width
localparam logic [xlen-1:0] pc0  = '0;  // first fetch address

typedef logic [31:0] op_t;  // raw instruction word

//////////////////////////////////////////////////////////////////////
// encodings
//////////////////////////////////////////////////////////////////////

// major opcodes, op[6:0]
typedef enum logic [6:0] {
  opc_lui    = 7'b0110111,
  opc_auipc  = 7'b0010111,
  opc_jal    = 7'b1101111,
  opc_jalr   = 7'b1100111,
  opc_branch = 7'b1100011,
  opc_load   = 7'b0000011,
  opc_store  = 7'b0100011,
  opc_op_imm = 7'b0010011,
  opc_op     = 7'b0110011
} opc_t;

typedef enum logic [3:0] {
  alu_add,
  alu_sub,
  alu_sll,
  alu_slt,
  alu_sltu,
  alu_xor,
  alu_srl,
  alu_sra,
  alu_or,
  alu_and
} alu_op_t;

// branch condition, none for everything that is not a branch
typedef enum logic [2:0] {
  br_none,
  br_eq,
  br_ne,
  br_lt,
  br_ge,
  br_ltu,
  br_geu
} br_op_t;

typedef enum logic [1:0] {
  pc_pci,  // pc + 4
  pc_brn,  // pc + imm when taken
  pc_jmp   // adder sum, bit 0 cleared
} pc_sel_t;

typedef enum logic {a1_rs1, a1_pc } a1_sel_t;
typedef enum logic {a2_rs2, a2_imm} a2_sel_t;

typedef enum logic [2:0] {
  wb_none,
  wb_alu,
  wb_mem,
  wb_pci,  // link address
  wb_imm   // lui
} wb_sel_t;

// matches funct3[1:0] of loads and stores
typedef enum logic [1:0] {sz_b, sz_h, sz_w} ls_size_t;

//////////////////////////////////////////////////////////////////////
// decoded control and bus payloads
//////////////////////////////////////////////////////////////////////

typedef struct packed {
  alu_op_t         alu;
  br_op_t          br;
  pc_sel_t         pc;
  a1_sel_t         a1;
  a2_sel_t         a2;
  wb_sel_t         wb;
  logic            rs1_en;
  logic            rs2_en;
  logic            rd_en;
  logic [4:0]      rs1_adr;
  logic [4:0]      rs2_adr;
  logic [4:0]      rd_adr;
  logic            ls_en;   // load or store
  logic            ls_we;   // store
  ls_size_t        ls_sz;
  logic            ls_sg;   // sign extend load data
  logic [xlen-1:0] imm;
  logic            ill;     // unknown encoding
} ctl_t;

typedef struct packed {
  logic [xlen-1:0] adr;  // word aligned, pc only steps by 4
} ibus_req_t;

typedef struct packed {
  logic            we;   // write
  logic [xlen-1:0] adr;  // low two bits zero
  logic [3:0]      sel;  // byte lanes
  logic [xlen-1:0] wdt;  // already shifted onto its lanes
} dbus_req_t;

endpackage

`default_nettype wire

// File: hdl/rv_dec.sv
`timescale 1ns/1ps
`default_nettype none

module rv_dec import rv_core_pkg::*; (
  input  op_t  op,
  output ctl_t ctl
);

logic [2:0]      f3;
logic [6:0]      f7;
logic [xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

assign f3 = op[14:12];
assign f7 = op[31:25];

// immediate formats, all sign extended from op[31]
assign imm_i = {{20{op[31]}}, op[31:20]};
assign imm_s = {{20{op[31]}}, op[31:25], op[11:7]};
assign imm_b = {{19{op[31]}}, op[31], op[7], op[30:25], op[11:8], 1'b0};
assign imm_u = {op[31:12], 12'h000};
assign imm_j = {{11{op[31]}}, op[31], op[19:12], op[20], op[30:21], 1'b0};

// funct3 to alu op, alt picks sub/sra
function automatic alu_op_t alu_dec(input logic [2:0] fn, input logic alt);
  alu_op_t res;
  case (fn)
    3'b000:  res = alt ? alu_sub : alu_add;
    3'b001:  res = alu_sll;
    3'b010:  res = alu_slt;
    3'b011:  res = alu_sltu;
    3'b100:  res = alu_xor;
    3'b101:  res = alt ? alu_sra : alu_srl;
    3'b110:  res = alu_or;
    default: res = alu_and;
  endcase
  return res;
endfunction

always_comb begin
  ctl = '0;  // add, no branch, pc+4, rs1/rs2 operands, no write back
  ctl.rs1_adr = op[19:15];
  ctl.rs2_adr = op[24:20];
  ctl.rd_adr  = op[11:7];
  ctl.ls_sz   = ls_size_t'(f3[1:0]);
  ctl.ls_sg   = ~f3[2];  // lbu/lhu have f3[2] set
  case (op[6:0])
    opc_lui: begin
      ctl.rd_en = 1'b1;
      ctl.wb    = wb_imm;
      ctl.imm   = imm_u;
    end
    opc_auipc: begin
      ctl.rd_en = 1'b1;
      ctl.a1    = a1_pc;
      ctl.a2    = a2_imm;
      ctl.wb    = wb_alu;
      ctl.imm   = imm_u;
    end
    opc_jal: begin
      ctl.rd_en = 1'b1;
      ctl.a1    = a1_pc;  // target comes out of the adder
      ctl.a2    = a2_imm;
      ctl.pc    = pc_jmp;
      ctl.wb    = wb_pci;
      ctl.imm   = imm_j;
    end
    opc_jalr: begin
      ctl.rs1_en = 1'b1;
      ctl.rd_en  = 1'b1;
      ctl.a2     = a2_imm;
      ctl.pc     = pc_jmp;
      ctl.wb     = wb_pci;
      ctl.imm    = imm_i;
      ctl.ill    = (f3 != 3'b000);
    end
    opc_branch: begin
      ctl.rs1_en = 1'b1;  // compared in the alu
      ctl.rs2_en = 1'b1;
      ctl.a1     = a1_pc;  // adder gives the branch target
      ctl.a2     = a2_imm;
      ctl.pc     = pc_brn;
      ctl.imm    = imm_b;
      case (f3)
        3'b000:  ctl.br = br_eq;
        3'b001:  ctl.br = br_ne;
        3'b100:  ctl.br = br_lt;
        3'b101:  ctl.br = br_ge;
        3'b110:  ctl.br = br_ltu;
        3'b111:  ctl.br = br_geu;
        default: ctl.ill = 1'b1;
      endcase
    end
    opc_load: begin
      ctl.rs1_en = 1'b1;
      ctl.rd_en  = 1'b1;
      ctl.a2     = a2_imm;
      ctl.ls_en  = 1'b1;
      ctl.wb     = wb_mem;
      ctl.imm    = imm_i;
      ctl.ill    = (f3[1:0] == 2'b11) | (f3 == 3'b110);  // no lwu/ld
    end
    opc_store: begin
      ctl.rs1_en = 1'b1;
      ctl.rs2_en = 1'b1;
      ctl.a2     = a2_imm;
      ctl.ls_en  = 1'b1;
      ctl.ls_we  = 1'b1;
      ctl.imm    = imm_s;
      ctl.ill    = f3[2] | (f3[1:0] == 2'b11);
    end
    opc_op_imm: begin
      ctl.rs1_en = 1'b1;
      ctl.rd_en  = 1'b1;
      ctl.a2     = a2_imm;
      ctl.wb     = wb_alu;
      ctl.imm    = imm_i;
      ctl.alu    = alu_dec(f3, (f3 == 3'b101) & f7[5]);
      // shift amounts only, upper bits must be clean
      if (f3 == 3'b001) ctl.ill = (f7 != 7'b0000000);
      if (f3 == 3'b101) ctl.ill = (f7 != 7'b0000000) & (f7 != 7'b0100000);
    end
    opc_op: begin
      ctl.rs1_en = 1'b1;
      ctl.rs2_en = 1'b1;
      ctl.rd_en  = 1'b1;
      ctl.wb     = wb_alu;
      ctl.alu    = alu_dec(f3, f7[5]);
      if (f7 == 7'b0100000) ctl.ill = (f3 != 3'b000) & (f3 != 3'b101);
      else                  ctl.ill = (f7 != 7'b0000000);  // M ext lands here too
    end
    default: ctl.ill = 1'b1;
  endcase
  // unknown encoding runs as a nop
  if (ctl.ill) begin
    ctl.rd_en = 1'b0;
    ctl.ls_en = 1'b0;
    ctl.ls_we = 1'b0;
    ctl.br    = br_none;
    ctl.pc    = pc_pci;
    ctl.wb    = wb_none;
  end
end

endmodule

`default_nettype wire

// File: hdl/rv_gpr.sv
`timescale 1ns/1ps
`default_nettype none

module rv_gpr import rv_core_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            rs1_en,
  input  logic            rs2_en,
  input  logic            rd_en,
  input  logic [4:0]      rs1_adr,
  input  logic [4:0]      rs2_adr,
  input  logic [4:0]      rd_adr,
  output logic [xlen-1:0] rs1_dat,
  output logic [xlen-1:0] rs2_dat,
  input  logic [xlen-1:0] rd_dat
);

logic [xlen-1:0] gpr [1:31];  // x0 has no storage

always_ff @(posedge clk, posedge rst) begin
  if (rst) begin
    for (int i = 1; i < 32; i++) gpr[i] <= '0;
  end else if (rd_en && rd_adr != 5'd0) begin
    gpr[rd_adr] <= rd_dat;  // x0 writes dropped
  end
end

// x0 and unused ports read as zero
assign rs1_dat = (rs1_en && rs1_adr != 5'd0) ? gpr[rs1_adr] : '0;
assign rs2_dat = (rs2_en && rs2_adr != 5'd0) ? gpr[rs2_adr] : '0;

endmodule

`default_nettype wire

// File: hdl/rv_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_lsu import rv_core_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  ctl_t            ctl,
  input  logic [xlen-1:0] adr,  // byte address from the adder
  input  logic [xlen-1:0] wdt,  // rs2
  // data bus
  output logic            ls_req,
  output dbus_req_t       ls_req_p,
  input  logic [xlen-1:0] ls_rdt,
  input  logic            ls_ack,
  // load write back
  output logic [xlen-1:0] rdt,
  output logic            dly
);

logic [1:0]      lane;    // byte offset in the word
logic [xlen-1:0] rd_sh;   // read word moved down to lane 0
logic [xlen-1:0] rd_ext;  // extended load value

assign lane = adr[1:0];

// no new access while the load result waits for write back
assign ls_req = ctl.ls_en & ~dly;

//////////////////////////////////////////////////////////////////////
// request payload
//////////////////////////////////////////////////////////////////////

assign ls_req_p.we  = ctl.ls_we;
assign ls_req_p.adr = {adr[xlen-1:2], 2'b00};

always_comb begin
  case (ctl.ls_sz)
    sz_b: begin
      ls_req_p.sel = 4'b0001 << lane;
      ls_req_p.wdt = (wdt & 32'h0000_00ff) << {lane, 3'b000};
    end
    sz_h: begin
      ls_req_p.sel = 4'b0011 << lane;
      ls_req_p.wdt = (wdt & 32'h0000_ffff) << {lane, 3'b000};
    end
    default: begin  // word, lane is zero
      ls_req_p.sel = 4'b1111;
      ls_req_p.wdt = wdt;
    end
  endcase
end

//////////////////////////////////////////////////////////////////////
// read data
//////////////////////////////////////////////////////////////////////

assign rd_sh = ls_rdt >> {lane, 3'b000};

always_comb begin
  case (ctl.ls_sz)
    sz_b:    rd_ext = ctl.ls_sg ? {{24{rd_sh[7]}}, rd_sh[7:0]} : {24'h0, rd_sh[7:0]};
    sz_h:    rd_ext = ctl.ls_sg ? {{16{rd_sh[15]}}, rd_sh[15:0]} : {16'h0, rd_sh[15:0]};
    default: rd_ext = rd_sh;
  endcase
end

// bus data only valid in the ack cycle, keep it for the write back
always_ff @(posedge clk) begin
  if (ls_req & ls_ack & ~ctl.ls_we) rdt <= rd_ext;
end

// one cycle flag, register written while it is high
always_ff @(posedge clk, posedge rst) begin
  if (rst) dly <= 1'b0;
  else     dly <= ls_req & ls_ack & ~ctl.ls_we;
end

endmodule

`default_nettype wire

// File: sim.f
hdl/rv_core_pkg.sv
hdl/rv_dec.sv
hdl/rv_gpr.sv
hdl/rv_alu.sv
hdl/rv_lsu.sv
hdl/rv_core.sv
+incdir+verification
verification/rv_core_asserts.sv
verification/tb_rv_core.sv

// File: verification/rv_core_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_asserts import rv_core_pkg::*; (
  input logic      clk,
  input logic      rst,
  input logic      if_req,
  input ibus_req_t if_req_p,
  input logic      if_ack,
  input logic      ls_req,
  input dbus_req_t ls_req_p,
  input logic      ls_ack
);

//////////////////////////////////////////////////////////////////////
// handshake rules
//////////////////////////////////////////////////////////////////////

// back-pressure, fetch held until ack
ap_if_hold: assert property (@(posedge clk) disable iff (rst)
  if_req && !if_ack |=> if_req && $stable(if_req_p))
  else $error("fetch request dropped or changed before ack");

ap_ls_hold: assert property (@(posedge clk) disable iff (rst)
  ls_req && !ls_ack |=> ls_req && $stable(ls_req_p))
  else $error("data request dropped or changed before ack");

ap_rst_quiet: assert property (@(posedge clk)
  rst |-> !if_req && !ls_req)
  else $error("bus request while in reset");

// no fetch beside a load
ap_ld_excl: assert property (@(posedge clk) disable iff (rst)
  ls_req && !ls_req_p.we |-> !if_req)
  else $error("fetch overlaps a load");

endmodule

bind rv_core rv_core_asserts asrt0 (
  .clk      (clk),
  .rst      (rst),
  .if_req   (if_req),
  .if_req_p (if_req_p),
  .if_ack   (if_ack),
  .ls_req   (ls_req),
  .ls_req_p (ls_req_p),
  .ls_ack   (ls_ack)
);

`default_nettype wire

// File: verification/rv_ref_model.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// instruction level model, runs the whole program ahead of the DUT

logic [xlen-1:0] m_x   [0:31];   // model registers
logic [7:0]      m_mem [0:255];  // model data window

function automatic logic [xlen-1:0] model_alu(logic [2:0] f3, logic alt,
                                              logic [xlen-1:0] x, logic [xlen-1:0] y);
  logic signed [xlen-1:0] sx;
  sx = x;
  case (f3)
    3'd0: return alt ? x - y : x + y;
    3'd1: return x << y[4:0];
    3'd2: return ($signed(x) < $signed(y)) ? 1 : 0;
    3'd3: return (x < y) ? 1 : 0;
    3'd4: return x ^ y;
    3'd5: begin
      if (alt) return sx >>> y[4:0];  // arithmetic, kept in a signed temp
      return x >> y[4:0];
    end
    3'd6: return x | y;
    default: return x & y;
  endcase
endfunction

function automatic logic model_taken(logic [2:0] f3, logic [xlen-1:0] x, logic [xlen-1:0] y);
  case (f3)
    3'd0: return x == y;
    3'd1: return x != y;
    3'd4: return $signed(x) < $signed(y);
    3'd5: return $signed(x) >= $signed(y);
    3'd6: return x < y;
    default: return x >= y;
  endcase
endfunction

task automatic model_run();
  logic [xlen-1:0] pc, nxt, a, b, res, adr, imm_i, imm_s, imm_b, imm_j, dat;
  op_t op;
  logic [2:0] f3;
  logic [7:0] o;
  logic wr;
  ibus_req_t f;
  dbus_req_t rq;
  pc = pc0;
  for (int n = 0; n < 1000; n++) begin
    op = imem[pc[9:2]];
    f.adr = pc;
    exp_fetch.push_back(f);
    if (op == jself) break;  // end of program
    f3 = op[14:12];
    a = m_x[op[19:15]];
    b = m_x[op[24:20]];
    imm_i = {{20{op[31]}}, op[31:20]};
    imm_s = {{20{op[31]}}, op[31:25], op[11:7]};
    imm_b = {{19{op[31]}}, op[31], op[7], op[30:25], op[11:8], 1'b0};
    imm_j = {{11{op[31]}}, op[31], op[19:12], op[20], op[30:21], 1'b0};
    nxt = pc + 4;
    wr = 1'b1;
    res = '0;
    case (op[6:0])
      7'h37: res = {op[31:12], 12'h000};
      7'h17: res = pc + {op[31:12], 12'h000};
      7'h6f: begin res = nxt; nxt = pc + imm_j; end
      7'h67: begin res = nxt; nxt = (a + imm_i) & ~32'd1; end
      7'h63: begin
        wr = 1'b0;
        if (model_taken(f3, a, b)) nxt = pc + imm_b;
      end
      7'h03: begin
        adr = a + imm_i;
        o = adr[7:0];
        rq = '0;
        rq.adr = {adr[xlen-1:2], 2'b00};
        rq.sel = (f3[1:0] == 2'd0) ? 4'b0001 << adr[1:0] :
                 (f3[1:0] == 2'd1) ? 4'b0011 << adr[1:0] : 4'b1111;
        exp_ld.push_back(rq);
        case (f3)
          3'd0: res = {{24{m_mem[o][7]}}, m_mem[o]};
          3'd1: res = {{16{m_mem[o+1][7]}}, m_mem[o+1], m_mem[o]};
          3'd4: res = {24'h0, m_mem[o]};
          3'd5: res = {16'h0, m_mem[o+1], m_mem[o]};
          default: res = {m_mem[o+3], m_mem[o+2], m_mem[o+1], m_mem[o]};
        endcase
      end
      7'h23: begin
        wr = 1'b0;
        adr = a + imm_s;
        dat = (f3 == 3'd0) ? b & 32'hff : (f3 == 3'd1) ? b & 32'hffff : b;
        rq.we  = 1'b1;
        rq.adr = {adr[xlen-1:2], 2'b00};
        rq.sel = (f3 == 3'd0) ? 4'b0001 << adr[1:0] :
                 (f3 == 3'd1) ? 4'b0011 << adr[1:0] : 4'b1111;
        rq.wdt = dat << (8 * adr[1:0]);  // data moved onto its lanes
        exp_st.push_back(rq);
        for (int k = 0; k < 4; k++)
          if (rq.sel[k]) m_mem[{adr[7:2], 2'(k)}] = rq.wdt[8*k +: 8];
      end
      7'h13: res = model_alu(f3, op[30] & (f3 == 3'd5), a, imm_i);
      default: res = model_alu(f3, op[30], a, b);  // register-register
    endcase
    if (wr && op[11:7] != 5'd0) m_x[op[11:7]] = res;
    pc = nxt;
  end
endtask

`endif

// File: verification/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core import rv_core_pkg::*; ();

logic clk, rst;
logic if_req, if_ack, ls_req, ls_ack;
ibus_req_t if_req_p;
op_t if_rdt;
dbus_req_t ls_req_p;
logic [xlen-1:0] ls_rdt;

op_t imem [0:255];
logic [7:0] dmem [0:255];  // DUT side data window at 0x1000
ibus_req_t exp_fetch [$];
dbus_req_t exp_st [$], exp_ld [$];
op_t jself = 32'h0000_006f;  // jal x0, 0
logic [15:0] lfsr;
int fetch_err, store_err, load_err, other_err, cycles, limit, first_st, n_prog;
logic running, done, i_busy, d_busy, p_if_wait, p_ls_wait;
logic [1:0] i_wait, d_wait;
ibus_req_t p_if;
dbus_req_t p_ls;

`include "rv_ref_model.svh"

rv_core dut0 (.clk(clk), .rst(rst), .if_req(if_req), .if_req_p(if_req_p), .if_rdt(if_rdt),
  .if_ack(if_ack), .ls_req(ls_req), .ls_req_p(ls_req_p), .ls_rdt(ls_rdt), .ls_ack(ls_ack));

initial begin
  clk = 1'b0;
  forever #50 clk = ~clk;
end

//////////////////////////////////////////////////////////////////////
// stimulus helpers
//////////////////////////////////////////////////////////////////////

// fibonacci lfsr x^16+x^14+x^13+x^11 stepped once per bit
function automatic logic [31:0] rnd(int n);
  logic [31:0] v;
  logic fb;
  v = '0;
  for (int k = 0; k < n; k++) begin
    fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    v = {v[30:0], fb};
  end
  return v;
endfunction

function automatic logic [4:0] pick_rd();
  return 5'(rnd(5) % 30 + 1);  // x31 keeps the data base
endfunction

function automatic logic [7:0] fill_byte(logic [31:0] a);
  return (a[7:0] * 8'd29) ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
endfunction

task automatic gen_program();
  logic [2:0] f3;
  logic [11:0] imm;
  logic [7:0] off;
  int t, idx;
  first_st = 201;
  n_prog = first_st + 32;
  for (int i = 0; i < 256; i++) imem[i] = jself;
  imem[0] = {20'h00001, 5'd31, 7'h37};  // lui x31 with the data base 0x1000
  for (int i = 1; i < first_st; i++) begin
    t = i + rnd(3) + 1;  // forward target no further than the store block
    if (t > first_st) t = first_st;
    f3 = rnd(3);
    case (rnd(3))
      0: imem[i] = {((f3 == 0 || f3 == 5) && rnd(1)) ? 7'h20 : 7'h00,
                    5'(rnd(5)), 5'(rnd(5)), f3, pick_rd(), 7'h33};
      1: begin
        imm = rnd(12);
        if (f3 == 1) imm[11:5] = 7'h00;
        if (f3 == 5) imm[11:5] = rnd(1) ? 7'h20 : 7'h00;
        imem[i] = {imm, 5'(rnd(5)), f3, pick_rd(), 7'h13};
      end
      2: imem[i] = {20'(rnd(20)), pick_rd(), 7'h37};
      3: imem[i] = {20'(rnd(20)), pick_rd(), 7'h17};
      4: begin
        if (f3 == 2 || f3 == 3) f3 = f3 - 2;
        imm = 12'((t - i) * 2);  // b immediate in halfwords
        imem[i] = {1'b0, imm[9:4], 5'(rnd(5)), 5'(rnd(5)), f3, imm[3:0], 1'b0, 7'h63};
      end
      5: begin
        if (rnd(1)) imem[i] = {12'(t * 4), 5'd0, 3'd0, pick_rd(), 7'h67};  // jalr x0 base
        else imem[i] = {1'b0, 10'((t - i) * 2), 1'b0, 8'h00, pick_rd(), 7'h6f};
      end
      6: begin
        idx = rnd(3) % 5;
        f3 = (idx >= 3) ? 3'(idx + 1) : 3'(idx);
        off = rnd(8);
        if (f3[1:0] == 1) off[0] = 1'b0;
        if (f3[1:0] == 2) off[1:0] = 2'b00;
        imem[i] = {4'h0, off, 5'd31, f3, pick_rd(), 7'h03};
      end
      default: begin
        f3 = rnd(2) % 3;
        off = rnd(8);
        if (f3 == 1) off[0] = 1'b0;
        if (f3 == 2) off[1:0] = 2'b00;
        imem[i] = {4'h0, off[7:5], 5'(rnd(5)), 5'd31, f3, off[4:0], 7'h23};
      end
    endcase
  end
  // final register dump of x1 to x31
  for (int r = 1; r < 32; r++) imem[first_st + r - 1] = {7'((r - 1) >> 3), 5'(r), 5'd31, 3'd2,
                                                         5'((r - 1) * 4), 7'h23};
endtask

//////////////////////////////////////////////////////////////////////
// compare tasks
//////////////////////////////////////////////////////////////////////

task automatic check_fetch(ibus_req_t got, ibus_req_t exp);
  if (got !== exp) begin
    fetch_err++;
    $display("Fail %0t: fetch adr %h, expected %h", $time, got.adr, exp.adr);
  end
endtask

task automatic check_store(dbus_req_t got, dbus_req_t exp);
  if (got !== exp) begin
    store_err++;
    $display("Fail %0t: store %h/%b/%h, expected %h/%b/%h", $time,
             got.adr, got.sel, got.wdt, exp.adr, exp.sel, exp.wdt);
  end
endtask

task automatic check_load(dbus_req_t got, dbus_req_t exp);
  if (got.we !== exp.we || got.adr !== exp.adr || got.sel !== exp.sel) begin
    load_err++;
    $display("Fail %0t: load %h/%b, expected %h/%b", $time, got.adr, got.sel, exp.adr, exp.sel);
  end
endtask

//////////////////////////////////////////////////////////////////////
// memory models with 0 to 3 wait cycles
//////////////////////////////////////////////////////////////////////

always @(posedge clk) begin
  #1;
  if (rst || !ls_req) begin
    ls_ack = 1'b0;
    d_busy = 1'b0;
  end else begin
    if (!d_busy) begin
      d_wait = rnd(2);
      d_busy = 1'b1;
    end
    ls_ack = (d_wait == 0);
    if (d_wait == 0) d_busy = 1'b0;
    else d_wait--;
  end
  ls_rdt = {dmem[{ls_req_p.adr[7:2], 2'd3}], dmem[{ls_req_p.adr[7:2], 2'd2}],
            dmem[{ls_req_p.adr[7:2], 2'd1}], dmem[{ls_req_p.adr[7:2], 2'd0}]};
  #1;  // if_req follows ls_ack
  if (rst || !if_req) begin
    if_ack = 1'b0;
    i_busy = 1'b0;
  end else begin
    if (!i_busy) begin
      i_wait = rnd(2);
      i_busy = 1'b1;
    end
    if_ack = (i_wait == 0);
    if (i_wait == 0) i_busy = 1'b0;
    else i_wait--;
  end
  if_rdt = imem[if_req_p.adr[9:2]];
end

// transfers sampled mid cycle where all bus signals are settled
always @(negedge clk) begin
  if (rst && (if_req || ls_req)) begin
    other_err++;
    $display("request raised during reset at %0t", $time);
  end
  if (running && !done) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("RESULT: FAIL");
      $finish;
    end else begin
      if ((p_if_wait && (!if_req || if_req_p !== p_if)) ||
          (p_ls_wait && (!ls_req || ls_req_p !== p_ls)) ||
          (ls_req && !ls_req_p.we && if_req)) begin
        other_err++;
        $display("bus request broke the handshake rules at %0t", $time);
      end
      p_if_wait = if_req && !if_ack;
      p_ls_wait = ls_req && !ls_ack;
      p_if = if_req_p;
      p_ls = ls_req_p;
      if (if_req && if_ack) begin
        if (exp_fetch.size() > 0) check_fetch(if_req_p, exp_fetch.pop_front());
        else begin
          other_err++;
          $display("fetch at %0t that the program does not make", $time);
        end
      end
      if (ls_req && ls_ack) begin
        if (ls_req_p.we && exp_st.size() > 0) check_store(ls_req_p, exp_st.pop_front());
        else if (!ls_req_p.we && exp_ld.size() > 0) check_load(ls_req_p, exp_ld.pop_front());
        else begin
          other_err++;
          $display("data access at %0t that the program does not make", $time);
        end
        if (ls_req_p.we)
          for (int k = 0; k < 4; k++)
            if (ls_req_p.sel[k]) dmem[{ls_req_p.adr[7:2], 2'(k)}] = ls_req_p.wdt[8*k +: 8];
      end
      if (exp_fetch.size() == 0 && exp_st.size() == 0 && exp_ld.size() == 0) done = 1'b1;
    end
  end
end

//////////////////////////////////////////////////////////////////////
// main sequence
//////////////////////////////////////////////////////////////////////

initial begin
  rst = 1'b1;
  if_ack = 1'b0;
  ls_ack = 1'b0;
  if_rdt = '0;
  ls_rdt = '0;
  lfsr = 16'd5;
  {fetch_err, store_err, load_err, other_err, cycles} = '0;
  {running, done, i_busy, d_busy, p_if_wait, p_ls_wait} = '0;
  gen_program();
  limit = n_prog * 12;
  for (int i = 0; i < 256; i++) begin
    dmem[i] = fill_byte(32'h1000 + i);
    m_mem[i] = fill_byte(32'h1000 + i);
  end
  for (int r = 0; r < 32; r++) m_x[r] = '0;
  model_run();
  repeat (5) @(posedge clk);
  #1 rst = 1'b0;
  running = 1'b1;
  wait (done);
  $display("errors: fetch %0d store %0d load %0d other %0d",
           fetch_err, store_err, load_err, other_err);
  if (fetch_err + store_err + load_err + other_err == 0) $display("RESULT: PASS");
  else $display("RESULT: FAIL");
  $finish;
end

endmodule

`default_nettype wire
